// File: decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath and address width
`define XLEN        32

// general register file
`define REG_ADDR_W  5
`define REG_NUM     32

// one bit per alu operation
`define ALU_OP_W    19

// exception codes raised in decode
`define ECODE_W     8
`define ECODE_SYS   8'h0B
`define ECODE_BRK   8'h0C
`define ECODE_INE   8'h0D

`endif

// File: isa_pkg.sv
`include "decode_config.svh"

package isa_pkg;

    typedef logic [16:0] op_3r_t;
    typedef logic [9:0]  op_2ri12_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // register-register layout
    typedef struct packed {
        op_3r_t    op_31_15;
        reg_addr_t rk;
        reg_addr_t rj;
        reg_addr_t rd;
    } inst_3r_t;

    // register-immediate layout, also loads and stores
    typedef struct packed {
        op_2ri12_t   op_31_22;
        logic [11:0] i12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_2ri12_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
    } inst_word_u;

    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD   = 0,
                   ALU_SUB   = 1,
                   ALU_SLT   = 2,
                   ALU_SLTU  = 3,
                   ALU_AND   = 4,
                   ALU_NOR   = 5,
                   ALU_OR    = 6,
                   ALU_XOR   = 7,
                   ALU_SLL   = 8,
                   ALU_SRL   = 9,
                   ALU_SRA   = 10,
                   ALU_LUI   = 11,
                   ALU_MUL   = 12,
                   ALU_MULH  = 13,
                   ALU_MULHU = 14,
                   ALU_DIV   = 15,
                   ALU_MOD   = 16,
                   ALU_DIVU  = 17,
                   ALU_MODU  = 18;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_t;

    typedef logic [3:0] mem_kind_t;

    // loads: size and unsigned bit, stores: byte enables
    localparam mem_kind_t MEM_NONE = 4'b0000;
    localparam mem_kind_t LD_B     = 4'b0001;
    localparam mem_kind_t LD_H     = 4'b0011;
    localparam mem_kind_t LD_BU    = 4'b0101;
    localparam mem_kind_t LD_HU    = 4'b0111;
    localparam mem_kind_t LD_W     = 4'b1111;
    localparam mem_kind_t ST_B     = 4'b0001;
    localparam mem_kind_t ST_H     = 4'b0011;
    localparam mem_kind_t ST_W     = 4'b1111;

endpackage

// File: pipe_pkg.sv
`include "decode_config.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        inst_word_u       inst;
    } fd_bus_t;

    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        alu_op_t             alu_op;
        logic [`XLEN-1:0]    alu_src1;
        logic [`XLEN-1:0]    alu_src2;
        logic [`XLEN-1:0]    store_data;
        logic                gr_we;
        reg_addr_t           dest;
        mem_kind_t           load_kind;
        mem_kind_t           store_be;
        br_kind_t            br_kind;
        logic [`XLEN-1:0]    br_target;
        logic                ex;
        logic [`ECODE_W-1:0] ecode;
    } de_bus_t;

    // execute only tells who it writes, data is not ready yet
    typedef struct packed {
        logic      we;
        reg_addr_t dest;
    } e_fwd_t;

    typedef struct packed {
        logic             we;
        reg_addr_t        dest;
        logic [`XLEN-1:0] data;
    } mw_fwd_t;

    typedef struct packed {
        alu_op_t          alu_op;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic [`XLEN-1:0] imm;
        logic             gr_we;
        reg_addr_t        dest;
        reg_addr_t        raddr1;
        reg_addr_t        raddr2;
        mem_kind_t        load_kind;
        mem_kind_t        store_be;
        br_kind_t         br_kind;
        logic [`XLEN-1:0] br_offs;
        logic             syscall;
        logic             brk;
        logic             unknown;
    } ctrl_t;

endpackage

// File: inst_decoder.sv
`include "decode_config.svh"

module inst_decoder
    import isa_pkg::*, pipe_pkg::*;
(
    input  inst_word_u inst,
    output ctrl_t      ctrl
);

    logic [`XLEN-1:0] imm;

    wire op_3r_t    op3r = inst.r3.op_31_15;
    wire op_2ri12_t op12 = inst.ri12.op_31_22;
    wire [5:0]      op6  = op12[9:4];
    wire reg_addr_t rd   = inst.r3.rd;
    wire reg_addr_t rj   = inst.r3.rj;
    wire reg_addr_t rk   = inst.r3.rk;
    wire [11:0]     i12  = inst.ri12.i12;
    wire [15:0]     i16  = inst[25:10];
    wire [19:0]     i20  = inst[24:5];
    wire [25:0]     i26  = {inst[9:0], inst[25:10]};

    // three-register group
    wire add_w   = op3r == 17'h00020;
    wire sub_w   = op3r == 17'h00022;
    wire slt     = op3r == 17'h00024;
    wire sltu    = op3r == 17'h00025;
    wire nor_    = op3r == 17'h00028;
    wire and_    = op3r == 17'h00029;
    wire or_     = op3r == 17'h0002a;
    wire xor_    = op3r == 17'h0002b;
    wire sll_w   = op3r == 17'h0002e;
    wire srl_w   = op3r == 17'h0002f;
    wire sra_w   = op3r == 17'h00030;
    wire mul_w   = op3r == 17'h00038;
    wire mulh_w  = op3r == 17'h00039;
    wire mulh_wu = op3r == 17'h0003a;
    wire div_w   = op3r == 17'h00040;
    wire mod_w   = op3r == 17'h00041;
    wire div_wu  = op3r == 17'h00042;
    wire mod_wu  = op3r == 17'h00043;
    wire brk     = op3r == 17'h00054;
    wire syscall = op3r == 17'h00056;
    wire slli_w  = op3r == 17'h00081;
    wire srli_w  = op3r == 17'h00089;
    wire srai_w  = op3r == 17'h00091;

    // twelve-bit immediate group
    wire slti    = op12 == 10'h008;
    wire sltui   = op12 == 10'h009;
    wire addi_w  = op12 == 10'h00a;
    wire andi    = op12 == 10'h00d;
    wire ori     = op12 == 10'h00e;
    wire xori    = op12 == 10'h00f;
    wire ld_b    = op12 == 10'h0a0;
    wire ld_h    = op12 == 10'h0a1;
    wire ld_w    = op12 == 10'h0a2;
    wire st_b    = op12 == 10'h0a4;
    wire st_h    = op12 == 10'h0a5;
    wire st_w    = op12 == 10'h0a6;
    wire ld_bu   = op12 == 10'h0a8;
    wire ld_hu   = op12 == 10'h0a9;
    wire lu12i_w = op12[9:3] == 7'b0001010;

    wire jirl    = op6 == 6'h13;
    wire b       = op6 == 6'h14;
    wire bl      = op6 == 6'h15;
    wire beq     = op6 == 6'h16;
    wire bne     = op6 == 6'h17;
    wire blt     = op6 == 6'h18;
    wire bge     = op6 == 6'h19;
    wire bltu    = op6 == 6'h1a;
    wire bgeu    = op6 == 6'h1b;

    wire is_load   = ld_b | ld_h | ld_w | ld_bu | ld_hu;
    wire is_store  = st_b | st_h | st_w;
    wire is_cbr    = beq | bne | blt | bge | bltu | bgeu;
    wire need_ui5  = slli_w | srli_w | srai_w;
    wire need_ui12 = andi | ori | xori;
    wire src2_is_4 = jirl | bl;
    wire is_alu3r  = add_w | sub_w | slt | sltu | nor_ | and_ | or_ | xor_ |
                     sll_w | srl_w | sra_w | mul_w | mulh_w | mulh_wu |
                     div_w | mod_w | div_wu | mod_wu;
    wire is_alui   = need_ui5 | need_ui12 | slti | sltui | addi_w | lu12i_w;
    wire unknown   = ~(is_alu3r | is_alui | is_load | is_store | is_cbr |
                       jirl | b | bl | brk | syscall);

    always_comb begin
        if (src2_is_4) begin
            imm = 32'd4;
        end else if (lu12i_w) begin
            imm = {i20, 12'b0};
        end else if (need_ui12) begin
            imm = {20'b0, i12};
        end else if (need_ui5) begin
            imm = {27'b0, rk};
        end else if (is_cbr) begin
            imm = {{14{i16[15]}}, i16, 2'b0};
        end else begin
            imm = {{20{i12[11]}}, i12};
        end
    end

    always_comb begin
        ctrl = '0;
        // memory address and link value also go through the adder
        ctrl.alu_op[ALU_ADD]   = add_w | addi_w | is_load | is_store | jirl | bl;
        ctrl.alu_op[ALU_SUB]   = sub_w | beq | bne;
        ctrl.alu_op[ALU_SLT]   = slt | slti | blt | bge;
        ctrl.alu_op[ALU_SLTU]  = sltu | sltui | bltu | bgeu;
        ctrl.alu_op[ALU_AND]   = and_ | andi;
        ctrl.alu_op[ALU_NOR]   = nor_;
        ctrl.alu_op[ALU_OR]    = or_ | ori;
        ctrl.alu_op[ALU_XOR]   = xor_ | xori;
        ctrl.alu_op[ALU_SLL]   = sll_w | slli_w;
        ctrl.alu_op[ALU_SRL]   = srl_w | srli_w;
        ctrl.alu_op[ALU_SRA]   = sra_w | srai_w;
        ctrl.alu_op[ALU_LUI]   = lu12i_w;
        ctrl.alu_op[ALU_MUL]   = mul_w;
        ctrl.alu_op[ALU_MULH]  = mulh_w;
        ctrl.alu_op[ALU_MULHU] = mulh_wu;
        ctrl.alu_op[ALU_DIV]   = div_w;
        ctrl.alu_op[ALU_MOD]   = mod_w;
        ctrl.alu_op[ALU_DIVU]  = div_wu;
        ctrl.alu_op[ALU_MODU]  = mod_wu;

        ctrl.src1_is_pc  = jirl | bl;
        ctrl.src2_is_imm = is_alui | is_load | is_store | src2_is_4;
        ctrl.imm         = imm;
        ctrl.gr_we       = ~(is_store | is_cbr | b | brk | syscall | unknown);
        ctrl.dest        = bl ? 5'd1 : rd;
        ctrl.raddr1      = rj;
        // branches and stores read rd as second source
        ctrl.raddr2      = (is_cbr | is_store) ? rd : rk;

        ctrl.load_kind = ld_w  ? LD_W  :
                         ld_b  ? LD_B  :
                         ld_bu ? LD_BU :
                         ld_h  ? LD_H  :
                         ld_hu ? LD_HU : MEM_NONE;
        ctrl.store_be  = st_w  ? ST_W  :
                         st_b  ? ST_B  :
                         st_h  ? ST_H  : MEM_NONE;

        ctrl.br_kind = beq  ? BR_BEQ  :
                       bne  ? BR_BNE  :
                       blt  ? BR_BLT  :
                       bge  ? BR_BGE  :
                       bltu ? BR_BLTU :
                       bgeu ? BR_BGEU :
                       b    ? BR_B    :
                       bl   ? BR_BL   :
                       jirl ? BR_JIRL : BR_NONE;
        ctrl.br_offs = (b | bl)       ? {{4{i26[25]}}, i26, 2'b0} :
                       (is_cbr | jirl) ? {{14{i16[15]}}, i16, 2'b0} : '0;

        ctrl.syscall = syscall;
        ctrl.brk     = brk;
        ctrl.unknown = unknown;
    end

endmodule

// File: regfile.sv
`include "decode_config.svh"

module regfile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata
);

    logic [`XLEN-1:0] rf [`REG_NUM];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: operand_bypass.sv
`include "decode_config.svh"

module operand_bypass
    import pipe_pkg::*;
(
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  logic [`XLEN-1:0]       rdata1,
    input  logic [`XLEN-1:0]       rdata2,
    input  e_fwd_t                 e_fwd,
    input  mw_fwd_t                m_fwd,
    input  mw_fwd_t                w_fwd,
    output logic [`XLEN-1:0]       rj_value,
    output logic [`XLEN-1:0]       rkd_value,
    output logic                   stall
);

    // r0 never matches, it stays zero
    function automatic logic hit(
        input logic                   we,
        input logic [`REG_ADDR_W-1:0] dest,
        input logic [`REG_ADDR_W-1:0] addr
    );
        return we && (addr != '0) && (dest == addr);
    endfunction

    // younger result wins
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rdata,
        input mw_fwd_t                m,
        input mw_fwd_t                w
    );
        logic [`XLEN-1:0] val;
        if (hit(m.we, m.dest, addr)) begin
            val = m.data;
        end else if (hit(w.we, w.dest, addr)) begin
            val = w.data;
        end else begin
            val = rdata;
        end
        return val;
    endfunction

    assign rj_value  = pick(raddr1, rdata1, m_fwd, w_fwd);
    assign rkd_value = pick(raddr2, rdata2, m_fwd, w_fwd);

    // execute result not available yet, covers loads too
    assign stall = hit(e_fwd.we, e_fwd.dest, raddr1) |
                   hit(e_fwd.we, e_fwd.dest, raddr2);

endmodule

// File: decode_stage.sv
`include "decode_config.svh"

module decode_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    fd_valid,
    input  fd_bus_t fd_bus,
    output logic    d_allowin,
    input  logic    e_allowin,
    output logic    de_valid,
    output de_bus_t de_bus,
    input  e_fwd_t  e_fwd,
    input  mw_fwd_t m_fwd,
    input  mw_fwd_t w_fwd,
    input  logic    ex_flush
);

    fd_bus_t             fd_r;
    logic                d_valid;
    logic                ex_pending;
    logic                ready_go;
    logic                stall;
    ctrl_t               ctrl;
    logic [`XLEN-1:0]    rf_rdata1;
    logic [`XLEN-1:0]    rf_rdata2;
    logic [`XLEN-1:0]    rj_value;
    logic [`XLEN-1:0]    rkd_value;
    logic [`XLEN-1:0]    br_base;
    logic                ex;
    logic [`ECODE_W-1:0] ecode;

    assign ready_go  = d_valid & ~stall;
    assign d_allowin = ~d_valid | (ready_go & e_allowin);
    assign de_valid  = d_valid & ready_go;

    always_ff @(posedge clk) begin
        if (fd_valid && d_allowin) begin
            fd_r <= fd_bus;
        end
    end

    // words after a leaving exception are taken in but marked invalid
    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_valid <= 1'b0;
        end else if (ex_flush) begin
            d_valid <= 1'b0;
        end else if (d_allowin) begin
            d_valid <= fd_valid & ~ex_pending & ~(de_valid & ex);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_pending <= 1'b0;
        end else if (ex_flush) begin
            ex_pending <= 1'b0;
        end else if (de_valid && e_allowin && ex) begin
            ex_pending <= 1'b1;
        end
    end

    inst_decoder u_inst_decoder (
        .inst (fd_r.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (w_fwd.we),
        .waddr  (w_fwd.dest),
        .wdata  (w_fwd.data)
    );

    operand_bypass u_operand_bypass (
        .raddr1    (ctrl.raddr1),
        .raddr2    (ctrl.raddr2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .e_fwd     (e_fwd),
        .m_fwd     (m_fwd),
        .w_fwd     (w_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    // priority syscall, break, unknown
    assign ex    = ctrl.syscall | ctrl.brk | ctrl.unknown;
    assign ecode = ctrl.syscall ? `ECODE_SYS :
                   ctrl.brk     ? `ECODE_BRK :
                   ctrl.unknown ? `ECODE_INE : '0;

    // jirl jumps off rj, everything else off pc
    assign br_base = (ctrl.br_kind == BR_JIRL) ? rj_value : fd_r.pc;

    always_comb begin
        de_bus            = '0;
        de_bus.pc         = fd_r.pc;
        de_bus.alu_op     = ctrl.alu_op;
        de_bus.alu_src1   = ctrl.src1_is_pc ? fd_r.pc : rj_value;
        de_bus.alu_src2   = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        de_bus.store_data = rkd_value;
        de_bus.gr_we      = ctrl.gr_we;
        de_bus.dest       = ctrl.dest;
        de_bus.load_kind  = ctrl.load_kind;
        de_bus.store_be   = ctrl.store_be;
        de_bus.br_kind    = ctrl.br_kind;
        de_bus.br_target  = br_base + ctrl.br_offs;
        de_bus.ex         = ex;
        de_bus.ecode      = ecode;
    end

endmodule

// File: tb_decode_stage.sv
`include "decode_config.svh"

module tb_decode_stage
    import isa_pkg::*, pipe_pkg::*;
();

    // about 120 cycles of tests, doubled for the limit
    localparam int TEST_CYCLES = 120;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic    clk;
    logic    rstn;
    logic    fd_valid;
    fd_bus_t fd_bus;
    logic    d_allowin;
    logic    e_allowin;
    logic    de_valid;
    de_bus_t de_bus;
    e_fwd_t  e_fwd;
    mw_fwd_t m_fwd;
    mw_fwd_t w_fwd;
    logic    ex_flush;

    de_bus_t          exp_bus;
    de_bus_t          care;
    string            test_name;
    logic             quiet;
    logic             hold;
    logic [`XLEN-1:0] golden [`REG_NUM];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] word;
    logic [`XLEN-1:0] d_mem;
    logic [`XLEN-1:0] d_wb;
    integer           seed;
    int               errors;
    int               checked;
    int               cycles;

    decode_stage DUT (
        .clk       (clk),
        .rstn      (rstn),
        .fd_valid  (fd_valid),
        .fd_bus    (fd_bus),
        .d_allowin (d_allowin),
        .e_allowin (e_allowin),
        .de_valid  (de_valid),
        .de_bus    (de_bus),
        .e_fwd     (e_fwd),
        .m_fwd     (m_fwd),
        .w_fwd     (w_fwd),
        .ex_flush  (ex_flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // only the fields a test cares about are compared
    bus_check: assert property (@(posedge clk) disable iff (!rstn)
            (de_valid && e_allowin) |-> (((de_bus ^ exp_bus) & care) == '0))
        else begin
            errors = errors + 1;
            $display("ERROR %s: expected %h actual %h", test_name,
                     exp_bus & care, $sampled(de_bus) & care);
        end

    quiet_check: assert property (@(posedge clk) disable iff (!rstn)
            quiet |-> !de_valid)
        else begin
            errors = errors + 1;
            $display("de_valid went high in %s while the stage should give nothing", test_name);
        end

    hold_check: assert property (@(posedge clk) disable iff (!rstn)
            hold |-> (de_valid && !d_allowin))
        else begin
            errors = errors + 1;
            $display("stage let go of its content under back-pressure in %s", test_name);
        end

    stable_check: assert property (@(posedge clk) disable iff (!rstn)
            (hold && $past(hold)) |-> (de_bus == $past(de_bus)))
        else begin
            errors = errors + 1;
            $display("de_bus changed under back-pressure in %s", test_name);
        end

    function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rk,
                                            input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [11:0] i12,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] br16_word(input logic [5:0] op, input logic [15:0] i16,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, i16, rj, rd};
    endfunction

    // offs[15:0] sits above offs[25:16]
    function automatic logic [31:0] br26_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] offs16(input logic [15:0] v);
        return {{14{v[15]}}, v, 2'b00};
    endfunction

    function automatic logic [31:0] offs26(input logic [25:0] v);
        return {{4{v[25]}}, v, 2'b00};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic new_expect(input string name);
        test_name  = name;
        exp_bus    = '0;
        care       = '0;
        exp_bus.pc = pc;
        care.pc    = '1;
        care.ex    = 1'b1;
    endtask

    task automatic want_src(input logic [31:0] src1, input logic [31:0] src2);
        exp_bus.alu_src1 = src1;
        exp_bus.alu_src2 = src2;
        care.alu_src1    = '1;
        care.alu_src2    = '1;
    endtask

    task automatic want_alu(input int op, input logic [31:0] src1, input logic [31:0] src2);
        exp_bus.alu_op     = '0;
        exp_bus.alu_op[op] = 1'b1;
        care.alu_op        = '1;
        want_src(src1, src2);
    endtask

    // negative dest means any
    task automatic want_write(input logic we, input int dest);
        exp_bus.gr_we = we;
        care.gr_we    = 1'b1;
        if (dest >= 0) begin
            exp_bus.dest = reg_addr_t'(dest);
            care.dest    = '1;
        end
    endtask

    task automatic want_mem(input mem_kind_t ld, input mem_kind_t st,
                            input logic [31:0] data, input logic data_care);
        exp_bus.load_kind = ld;
        exp_bus.store_be  = st;
        care.load_kind    = '1;
        care.store_be     = '1;
        if (data_care) begin
            exp_bus.store_data = data;
            care.store_data    = '1;
        end
    endtask

    task automatic want_jump(input br_kind_t kind, input logic [31:0] target);
        exp_bus.br_kind   = kind;
        exp_bus.br_target = target;
        care.br_kind      = br_kind_t'(4'hf);
        care.br_target    = '1;
    endtask

    task automatic want_trap(input logic [`ECODE_W-1:0] code);
        exp_bus.ex    = 1'b1;
        exp_bus.ecode = code;
        care.ecode    = '1;
    endtask

    task automatic send(input logic [31:0] inst);
        logic taken;
        taken    = 1'b0;
        fd_valid = 1'b1;
        fd_bus   = fd_bus_t'({pc, inst});
        while (!taken) begin
            @(negedge clk);
            taken = d_allowin;
            step();
        end
        fd_valid = 1'b0;
        pc       = pc + 4;
    endtask

    task automatic wait_leave();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = de_valid && e_allowin;
            step();
        end
        checked = checked + 1;
    endtask

    task automatic run_inst(input logic [31:0] inst);
        send(inst);
        wait_leave();
    endtask

    task automatic trap_and_flush(input string name, input logic [31:0] inst,
                                  input logic [`ECODE_W-1:0] code);
        new_expect(name);
        want_trap(code);
        run_inst(inst);
        // younger words vanish until the flush
        quiet = 1'b1;
        send(r3_word(17'h00020, 5'd7, 5'd6, 5'd5));
        repeat (3) step();
        quiet    = 1'b0;
        ex_flush = 1'b1;
        step();
        ex_flush = 1'b0;
    endtask

    initial begin
        rstn      = 1'b0;
        fd_valid  = 1'b0;
        fd_bus    = '0;
        e_allowin = 1'b1;
        e_fwd     = '0;
        m_fwd     = '0;
        w_fwd     = '0;
        ex_flush  = 1'b0;
        quiet     = 1'b0;
        hold      = 1'b0;
        exp_bus   = '0;
        care      = '0;
        test_name = "reset";
        seed      = 16614;
        errors    = 0;
        checked   = 0;
        cycles    = 0;
        pc        = 32'h1c00_0000;
        golden[0] = '0;

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        after_reset: assert (d_allowin && !de_valid)
            else begin
                errors = errors + 1;
                $display("stage is not empty after reset");
            end
        step();

        // load the register file through the write-back port
        for (int i = 1; i < `REG_NUM; i++) begin
            golden[i] = $random(seed);
            w_fwd     = mw_fwd_t'({1'b1, reg_addr_t'(i), golden[i]});
            step();
        end
        w_fwd = '0;

        new_expect("add.w");
        want_alu(ALU_ADD, golden[6], golden[7]);
        want_write(1'b1, 5);
        run_inst(r3_word(17'h00020, 5'd7, 5'd6, 5'd5));

        new_expect("sub.w");
        want_alu(ALU_SUB, golden[8], golden[9]);
        want_write(1'b1, 4);
        run_inst(r3_word(17'h00022, 5'd9, 5'd8, 5'd4));

        new_expect("and");
        want_alu(ALU_AND, golden[20], golden[21]);
        want_write(1'b1, 22);
        run_inst(r3_word(17'h00029, 5'd21, 5'd20, 5'd22));

        new_expect("mul.w");
        want_alu(ALU_MUL, golden[30], golden[31]);
        want_write(1'b1, 29);
        run_inst(r3_word(17'h00038, 5'd31, 5'd30, 5'd29));

        new_expect("addi.w");
        want_alu(ALU_ADD, golden[6], sext12(12'h8f3));
        want_write(1'b1, 5);
        run_inst(ri12_word(10'h00a, 12'h8f3, 5'd6, 5'd5));

        new_expect("andi");
        want_alu(ALU_AND, golden[6], {20'b0, 12'hf0f});
        want_write(1'b1, 5);
        run_inst(ri12_word(10'h00d, 12'hf0f, 5'd6, 5'd5));

        new_expect("slli.w");
        want_alu(ALU_SLL, golden[6], 32'd13);
        want_write(1'b1, 5);
        run_inst(r3_word(17'h00081, 5'd13, 5'd6, 5'd5));

        // lu12i.w has no rj, its field is part of si20
        word = {7'b0001010, 20'habcde, 5'd5};
        new_expect("lu12i.w");
        want_alu(ALU_LUI, golden[word[9:5]], {20'habcde, 12'b0});
        want_write(1'b1, 5);
        run_inst(word);

        new_expect("ld.b");
        want_write(1'b1, 11);
        want_mem(LD_B, MEM_NONE, '0, 1'b0);
        run_inst(ri12_word(10'h0a0, 12'h010, 5'd10, 5'd11));

        new_expect("ld.h");
        want_write(1'b1, 11);
        want_mem(LD_H, MEM_NONE, '0, 1'b0);
        run_inst(ri12_word(10'h0a1, 12'h012, 5'd10, 5'd11));

        new_expect("ld.w");
        want_write(1'b1, 11);
        want_mem(LD_W, MEM_NONE, '0, 1'b0);
        run_inst(ri12_word(10'h0a2, 12'h014, 5'd10, 5'd11));

        new_expect("ld.bu");
        want_write(1'b1, 11);
        want_mem(LD_BU, MEM_NONE, '0, 1'b0);
        run_inst(ri12_word(10'h0a8, 12'hff1, 5'd10, 5'd11));

        new_expect("ld.hu");
        want_write(1'b1, 11);
        want_mem(LD_HU, MEM_NONE, '0, 1'b0);
        run_inst(ri12_word(10'h0a9, 12'hff2, 5'd10, 5'd11));

        new_expect("st.b");
        want_write(1'b0, -1);
        want_mem(MEM_NONE, ST_B, golden[12], 1'b1);
        run_inst(ri12_word(10'h0a4, 12'h020, 5'd10, 5'd12));

        new_expect("st.h");
        want_write(1'b0, -1);
        want_mem(MEM_NONE, ST_H, golden[13], 1'b1);
        run_inst(ri12_word(10'h0a5, 12'h022, 5'd10, 5'd13));

        new_expect("st.w");
        want_write(1'b0, -1);
        want_mem(MEM_NONE, ST_W, golden[18], 1'b1);
        run_inst(ri12_word(10'h0a6, 12'h024, 5'd10, 5'd18));

        new_expect("beq");
        want_write(1'b0, -1);
        want_jump(BR_BEQ, pc + offs16(16'hfff0));
        run_inst(br16_word(6'h16, 16'hfff0, 5'd14, 5'd15));

        new_expect("jirl");
        want_write(1'b1, 17);
        want_jump(BR_JIRL, golden[16] + offs16(16'h0041));
        run_inst(br16_word(6'h13, 16'h0041, 5'd16, 5'd17));

        new_expect("b");
        want_write(1'b0, -1);
        want_jump(BR_B, pc + offs26(26'h3ff_fe00));
        run_inst(br26_word(6'h14, 26'h3ff_fe00));

        new_expect("bl");
        want_write(1'b1, 1);
        want_src(pc, 32'd4);
        want_jump(BR_BL, pc + offs26(26'h000_1234));
        run_inst(br26_word(6'h15, 26'h000_1234));

        // memory stage wins over write-back
        d_mem = $random(seed);
        d_wb  = $random(seed);
        new_expect("bypass from memory");
        want_src(d_mem, golden[8]);
        send(r3_word(17'h00020, 5'd8, 5'd7, 5'd9));
        m_fwd = mw_fwd_t'({1'b1, 5'd7, d_mem});
        w_fwd = mw_fwd_t'({1'b1, 5'd7, d_wb});
        wait_leave();
        m_fwd     = '0;
        w_fwd     = '0;
        golden[7] = d_wb;

        // write-back data reaches decode in the cycle it is written
        d_wb = $random(seed);
        new_expect("bypass from write-back");
        want_src(d_wb, golden[8]);
        send(r3_word(17'h00020, 5'd8, 5'd7, 5'd9));
        w_fwd = mw_fwd_t'({1'b1, 5'd7, d_wb});
        wait_leave();
        w_fwd     = '0;
        golden[7] = d_wb;

        m_fwd = mw_fwd_t'({1'b1, 5'd0, d_mem});
        w_fwd = mw_fwd_t'({1'b1, 5'd0, d_wb});
        new_expect("r0 reads zero");
        want_src('0, golden[8]);
        run_inst(r3_word(17'h00020, 5'd8, 5'd0, 5'd9));
        m_fwd = '0;
        w_fwd = '0;

        // rk is being produced in execute
        e_fwd = e_fwd_t'({1'b1, 5'd4});
        new_expect("stall on execute");
        want_alu(ALU_ADD, golden[3], golden[4]);
        quiet = 1'b1;
        send(r3_word(17'h00020, 5'd4, 5'd3, 5'd2));
        repeat (3) step();
        quiet    = 1'b0;
        e_fwd.we = 1'b0;
        wait_leave();

        e_allowin = 1'b0;
        new_expect("back-pressure");
        want_alu(ALU_SUB, golden[24], golden[25]);
        send(r3_word(17'h00022, 5'd25, 5'd24, 5'd23));
        hold = 1'b1;
        // the next word waits at the input meanwhile
        fd_valid = 1'b1;
        fd_bus   = fd_bus_t'({pc, r3_word(17'h00020, 5'd27, 5'd26, 5'd28)});
        repeat (4) step();
        hold      = 1'b0;
        e_allowin = 1'b1;
        wait_leave();
        fd_valid = 1'b0;
        new_expect("word behind back-pressure");
        want_alu(ALU_ADD, golden[26], golden[27]);
        wait_leave();
        pc = pc + 4;

        trap_and_flush("syscall", r3_word(17'h00056, 5'd0, 5'd0, 5'd3), `ECODE_SYS);
        trap_and_flush("break", r3_word(17'h00054, 5'd0, 5'd0, 5'd7), `ECODE_BRK);
        trap_and_flush("undefined word", 32'hffff_ffff, `ECODE_INE);

        new_expect("issue after flush");
        want_alu(ALU_ADD, golden[6], golden[7]);
        want_write(1'b1, 5);
        run_inst(r3_word(17'h00020, 5'd7, 5'd6, 5'd5));

        repeat (2) step();
        $display("instructions checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: decode_stage.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
decode_stage.sv
tb_decode_stage.sv
